//--- src/axis_pkt_pkg.sv
// shared widths and types for the store-and-forward packet buffer
// import into any module that needs the data word or gate state types

package axis_pkt_pkg;

    // default stream data width
    localparam int DATA_W = 32;

    // buffer depth in words, keep it a power of two
    localparam int DEPTH = 16;

    // one data beat on either stream
    typedef logic [DATA_W-1:0] word_t;

    // output gate modes
    //   ST_HOLD  : output closed, waiting for a whole packet
    //   ST_SEND  : forwarding one stored packet
    //   ST_FLUSH : cut-through for a packet longer than the FIFO
    typedef enum logic [1:0] {
        ST_HOLD  = 2'd0,
        ST_SEND  = 2'd1,
        ST_FLUSH = 2'd2
    } gate_state_e;

endpackage

//--- src/sync_fifo.sv
// single-clock fall-through FIFO, head word readable whenever not empty
// reports occupancy and almost-full / almost-empty levels

`timescale 1ns/1ps

module sync_fifo
    import axis_pkt_pkg::*;
#(
    parameter int FIFO_WIDTH = DATA_W + 1,
    parameter int FIFO_DEPTH = DEPTH
) (
    input  logic                        clk_i,
    input  logic                        reset_i,

    input  logic [FIFO_WIDTH-1:0]       data_i,
    input  logic                        push_i,
    input  logic                        pop_i,

    output logic [FIFO_WIDTH-1:0]       data_o,
    output logic                        empty_o,
    output logic                        full_o,
    output logic                        a_empty_o,
    output logic                        a_full_o,
    output logic [$clog2(FIFO_DEPTH):0] data_cnt_o
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;

    typedef logic [ADDR_W:0]  ptr_t; // extra wrap bit
    typedef logic [CNT_W-1:0] cnt_t;

    if ((1 << ADDR_W) != FIFO_DEPTH) begin : g_depth_check
        $error("FIFO_DEPTH has to be a power of two");
    end

    logic [FIFO_WIDTH-1:0] mem [FIFO_DEPTH];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t cnt_q;
    logic do_push;
    logic do_pop;

    // requests against full / empty are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
        end else if (do_push) begin
            wr_ptr_q <= wr_ptr_q + ptr_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
        end else if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + cnt_t'(1);
                2'b01:   cnt_q <= cnt_q - cnt_t'(1);
                default: cnt_q <= cnt_q; // idle or push+pop
            endcase
        end
    end

    // head word straight from the array
    assign data_o = mem[rd_ptr_q[ADDR_W-1:0]];

    assign empty_o = (wr_ptr_q == rd_ptr_q);

    // same address, opposite lap
    assign full_o = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                    (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

    assign a_full_o   = (cnt_q >= cnt_t'(FIFO_DEPTH - 1));
    assign a_empty_o  = (cnt_q <= cnt_t'(1));
    assign data_cnt_o = cnt_q;

endmodule

//--- src/axis_fifo_wrap.sv
// stream adapter around sync_fifo, stores tlast beside each data word
// input ready is FIFO not full, output valid is FIFO not empty

`timescale 1ns/1ps

module axis_fifo_wrap
    import axis_pkt_pkg::*;
#(
    parameter int FIFO_WIDTH = DATA_W,
    parameter int FIFO_DEPTH = DEPTH
) (
    input  logic                        clk_i,
    input  logic                        reset_i,

    input  logic [FIFO_WIDTH-1:0]       s_tdata_i,
    input  logic                        s_tvalid_i,
    input  logic                        s_tlast_i,
    output logic                        s_tready_o,

    output logic [FIFO_WIDTH-1:0]       m_tdata_o,
    output logic                        m_tvalid_o,
    output logic                        m_tlast_o,
    input  logic                        m_tready_i,

    output logic                        full_o,
    output logic                        a_full_o,
    output logic                        a_empty_o,
    output logic [$clog2(FIFO_DEPTH):0] data_cnt_o
);

    localparam int WORD_W = FIFO_WIDTH + 1; // tlast on top

    logic [WORD_W-1:0] wr_word;
    logic [WORD_W-1:0] rd_word;
    logic              push;
    logic              pop;
    logic              empty;

    assign wr_word = {s_tlast_i, s_tdata_i};
    assign {m_tlast_o, m_tdata_o} = rd_word;

    assign s_tready_o = ~full_o;
    assign m_tvalid_o = ~empty;

    assign push = s_tvalid_i & s_tready_o;
    assign pop  = m_tvalid_o & m_tready_i;

    sync_fifo #(
        .FIFO_WIDTH(WORD_W),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .data_i    (wr_word),
        .push_i    (push),
        .pop_i     (pop),
        .data_o    (rd_word),
        .empty_o   (empty),
        .full_o    (full_o),
        .a_empty_o (a_empty_o),
        .a_full_o  (a_full_o),
        .data_cnt_o(data_cnt_o)
    );

endmodule

//--- src/pkt_count.sv
// number of complete packets held in the buffer
// up on a stored tlast beat, down when the gate reports a tlast leaving

`timescale 1ns/1ps

module pkt_count
    import axis_pkt_pkg::*;
#(
    parameter int FIFO_DEPTH = DEPTH
) (
    input  logic clk_i,
    input  logic reset_i,

    input  logic s_tvalid_i,
    input  logic s_tready_i,
    input  logic s_tlast_i,

    input  logic pkt_done_i,
    output logic pkt_avail_o
);

    // worst case is a FIFO full of one-beat packets
    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    typedef logic [CNT_W-1:0] cnt_t;

    cnt_t pkt_cnt_q;
    logic inc;
    logic dec;

    assign inc = s_tvalid_i & s_tready_i & s_tlast_i;
    assign dec = pkt_done_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pkt_cnt_q <= '0;
        end else if (inc && !dec) begin
            pkt_cnt_q <= pkt_cnt_q + cnt_t'(1);
        end else if (dec && !inc) begin
            pkt_cnt_q <= pkt_cnt_q - cnt_t'(1);
        end
    end

    assign pkt_avail_o = (pkt_cnt_q != '0);

endmodule

//--- src/pkt_gate_fsm.sv
// output gate, opens for one whole stored packet at a time
// falls back to cut-through when the FIFO fills without a stored tlast

`timescale 1ns/1ps

module pkt_gate_fsm
    import axis_pkt_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,

    input  logic fifo_tvalid_i,
    input  logic fifo_tlast_i,
    input  logic fifo_full_i,
    input  logic pkt_avail_i,

    input  logic m_tready_i,
    output logic m_tvalid_o,
    output logic fifo_tready_o,
    output logic pkt_done_o
);

    gate_state_e state;
    gate_state_e state_nxt;

    logic gate_open;
    logic beat_out;
    logic last_out;

    assign gate_open = (state != ST_HOLD);

    assign m_tvalid_o    = gate_open & fifo_tvalid_i;
    assign fifo_tready_o = gate_open & m_tready_i;

    assign beat_out = m_tvalid_o & m_tready_i;
    assign last_out = beat_out & fifo_tlast_i;

    // also fires in FLUSH, the tlast was counted once it got stored
    assign pkt_done_o = last_out;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_HOLD: begin
                if (pkt_avail_i) begin
                    state_nxt = ST_SEND;
                end else if (fifo_full_i) begin
                    state_nxt = ST_FLUSH; // oversized packet
                end
            end
            ST_SEND, ST_FLUSH: begin
                // closing here leaves a bubble before the next packet
                if (last_out) begin
                    state_nxt = ST_HOLD;
                end
            end
            default: state_nxt = ST_HOLD;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= ST_HOLD;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- src/axis_pkt_buffer.sv
// store-and-forward AXI-Stream packet buffer, top level
// FIFO wrapper, packet counter and output gate on a single clock

`timescale 1ns/1ps

module axis_pkt_buffer
    import axis_pkt_pkg::*;
#(
    parameter int FIFO_WIDTH = DATA_W,
    parameter int FIFO_DEPTH = DEPTH
) (
    input  logic                        clk_i,
    input  logic                        reset_i,

    input  word_t                       s_axis_tdata_i,
    input  logic                        s_axis_tvalid_i,
    input  logic                        s_axis_tlast_i,
    output logic                        s_axis_tready_o,

    output word_t                       m_axis_tdata_o,
    output logic                        m_axis_tvalid_o,
    output logic                        m_axis_tlast_o,
    input  logic                        m_axis_tready_i,

    output logic                        a_full_o,
    output logic                        a_empty_o,
    output logic [$clog2(FIFO_DEPTH):0] data_cnt_o
);

    if (FIFO_WIDTH != $bits(word_t)) begin : g_width_check
        $error("FIFO_WIDTH does not match the stream word width");
    end

    logic fifo_tvalid;
    logic fifo_tlast;
    logic fifo_tready;
    logic fifo_full;
    logic pkt_done;
    logic pkt_avail;

    axis_fifo_wrap #(
        .FIFO_WIDTH(FIFO_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_wrap (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .s_tdata_i (s_axis_tdata_i),
        .s_tvalid_i(s_axis_tvalid_i),
        .s_tlast_i (s_axis_tlast_i),
        .s_tready_o(s_axis_tready_o),
        .m_tdata_o (m_axis_tdata_o),  // head word goes out directly
        .m_tvalid_o(fifo_tvalid),
        .m_tlast_o (fifo_tlast),
        .m_tready_i(fifo_tready),
        .full_o    (fifo_full),
        .a_full_o  (a_full_o),
        .a_empty_o (a_empty_o),
        .data_cnt_o(data_cnt_o)
    );

    pkt_count #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_count (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .s_tvalid_i (s_axis_tvalid_i),
        .s_tready_i (s_axis_tready_o),
        .s_tlast_i  (s_axis_tlast_i),
        .pkt_done_i (pkt_done),
        .pkt_avail_o(pkt_avail)
    );

    pkt_gate_fsm u_gate (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .fifo_tvalid_i(fifo_tvalid),
        .fifo_tlast_i (fifo_tlast),
        .fifo_full_i  (fifo_full),
        .pkt_avail_i  (pkt_avail),
        .m_tready_i   (m_axis_tready_i),
        .m_tvalid_o   (m_axis_tvalid_o),
        .fifo_tready_o(fifo_tready),
        .pkt_done_o   (pkt_done)
    );

    assign m_axis_tlast_o = fifo_tlast;

endmodule

//--- verif/axis_pkt_buffer_checker.sv
// port-level assertions for axis_pkt_buffer, bound into the DUT from the testbench
// every property raises its own flag on failure, fail_seen collects them

`timescale 1ns/1ps

module axis_pkt_buffer_checker
    import axis_pkt_pkg::*;
#(
    parameter int FIFO_DEPTH = DEPTH
) (
    input logic                        clk_i,
    input logic                        reset_i,
    input logic                        s_tready_i,
    input word_t                       m_tdata_i,
    input logic                        m_tvalid_i,
    input logic                        m_tlast_i,
    input logic                        m_tready_i,
    input logic                        a_full_i,
    input logic                        a_empty_i,
    input logic [$clog2(FIFO_DEPTH):0] data_cnt_i,
    input gate_state_e                 gate_state_i
);

    typedef logic [$clog2(FIFO_DEPTH):0] cnt_t;

    logic reset_bad = 1'b0;
    logic stall_bad = 1'b0;
    logic ready_bad = 1'b0;
    logic level_bad = 1'b0;
    logic gate_bad  = 1'b0;
    logic fail_seen;

    assign fail_seen = reset_bad | stall_bad | ready_bad | level_bad | gate_bad;

    reset_idle: assert property (@(posedge clk_i)
        reset_i |=> !m_tvalid_i && s_tready_i && !a_full_i && a_empty_i && data_cnt_i == '0)
        else begin
            reset_bad = 1'b1;
            $error("buffer not empty and idle after reset");
        end

    // head beat frozen while the sink stalls
    stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_tdata_i) && $stable(m_tlast_i))
        else begin
            stall_bad = 1'b1;
            $error("output beat changed while stalled");
        end

    ready_full: assert property (@(posedge clk_i) disable iff (reset_i)
        !s_tready_i |-> data_cnt_i == cnt_t'(FIFO_DEPTH))
        else begin
            ready_bad = 1'b1;
            $error("input ready low while the FIFO has room");
        end

    levels: assert property (@(posedge clk_i) disable iff (reset_i)
        (a_full_i == (data_cnt_i >= cnt_t'(FIFO_DEPTH - 1))) &&
        (a_empty_i == (data_cnt_i <= cnt_t'(1))))
        else begin
            level_bad = 1'b1;
            $error("almost-full or almost-empty does not match the word count");
        end

    // last beat out closes the gate, one idle cycle follows
    gate_close: assert property (@(posedge clk_i) disable iff (reset_i)
        m_tvalid_i && m_tready_i && m_tlast_i |=> gate_state_i == ST_HOLD && !m_tvalid_i)
        else begin
            gate_bad = 1'b1;
            $error("gate still open after the last beat of a packet");
        end

endmodule

//--- verif/tb_axis_pkt_buffer.sv
// testbench for axis_pkt_buffer, random packets of 1 to 24 beats with valid and ready gaps
// scoreboard and packet model checks run here, the bound checker watches the ports

`timescale 1ns/1ps

module tb_axis_pkt_buffer
    import axis_pkt_pkg::*;
();

    localparam int NUM_PKTS   = 40;
    localparam int MAX_LEN    = 24;
    localparam int MAX_CYCLES = NUM_PKTS * MAX_LEN * 4 + 1000; // every beat stalled, plus margin

    typedef logic [DATA_W:0] beat_t; // {tlast, tdata}

    logic                   clk;
    logic                   reset;
    word_t                  s_tdata;
    logic                   s_tvalid;
    logic                   s_tlast;
    logic                   s_tready;
    word_t                  m_tdata;
    logic                   m_tvalid;
    logic                   m_tlast;
    logic                   m_tready;
    logic                   a_full;
    logic                   a_empty;
    logic [$clog2(DEPTH):0] data_cnt;

    beat_t       exp_q[$];
    logic [31:0] in_rng      = 32'hb6cc;
    logic [31:0] out_rng     = 32'hb6cc ^ 32'h9e37_79b9; // own sequence for ready
    int          accepted    = 0;
    int          delivered   = 0;
    int          pkts_held   = 0; // complete packets inside the DUT
    int          cycles      = 0;
    logic        prev_tvalid = 1'b0;
    logic        out_mid     = 1'b0; // output is inside a packet

    bind axis_pkt_buffer axis_pkt_buffer_checker #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_checker (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .s_tready_i  (s_axis_tready_o),
        .m_tdata_i   (m_axis_tdata_o),
        .m_tvalid_i  (m_axis_tvalid_o),
        .m_tlast_i   (m_axis_tlast_o),
        .m_tready_i  (m_axis_tready_i),
        .a_full_i    (a_full_o),
        .a_empty_i   (a_empty_o),
        .data_cnt_i  (data_cnt_o),
        .gate_state_i(u_gate.state)
    );

    axis_pkt_buffer u_dut (
        .clk_i          (clk),
        .reset_i        (reset),
        .s_axis_tdata_i (s_tdata),
        .s_axis_tvalid_i(s_tvalid),
        .s_axis_tlast_i (s_tlast),
        .s_axis_tready_o(s_tready),
        .m_axis_tdata_o (m_tdata),
        .m_axis_tvalid_o(m_tvalid),
        .m_axis_tlast_o (m_tlast),
        .m_axis_tready_i(m_tready),
        .a_full_o       (a_full),
        .a_empty_o      (a_empty),
        .data_cnt_o     (data_cnt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping after the first failed check");
    endtask

    task automatic report_mismatch(input string test, input beat_t exp, input beat_t act);
        stop_failed($sformatf("[FAIL] %s expected %h actual %h", test, exp, act));
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // sink side, ready high about half the time
    initial begin
        m_tready <= 1'b0;
        forever begin
            @(posedge clk);
            out_rng = xorshift32(out_rng);
            m_tready <= out_rng[0];
        end
    end

    initial begin
        int len;
        reset    <= 1'b1;
        s_tdata  <= '0;
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            in_rng = xorshift32(in_rng);
            len = 1 + int'(in_rng % 32'(MAX_LEN));
            if (p == 0) len = MAX_LEN; // oversized, forces FLUSH early
            if (p == 1) len = 1;
            for (int b = 0; b < len; b++) begin
                in_rng = xorshift32(in_rng);
                if (in_rng[1:0] == 2'b00) begin
                    s_tvalid <= 1'b0;
                    @(posedge clk);
                end
                in_rng = xorshift32(in_rng);
                s_tdata  <= word_t'(in_rng);
                s_tlast  <= (b == len - 1);
                s_tvalid <= 1'b1;
                @(posedge clk);
                while (!s_tready) begin
                    @(posedge clk);
                end
            end
        end
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
        // monitor has counted the last accepted beat by the next falling edge
        do begin
            @(negedge clk);
        end while (delivered != accepted);
        repeat (2) @(posedge clk);
        if (u_dut.u_checker.fail_seen) begin
            stop_failed("run ended with a failed port assertion");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

    always @(posedge clk) begin
        beat_t got;
        beat_t exp_beat;
        if (reset) begin
            prev_tvalid = 1'b0;
            out_mid     = 1'b0;
        end else begin
            if (u_dut.u_checker.fail_seen) begin
                stop_failed("a port assertion in the bound checker failed");
            end
            assert (int'(data_cnt) == accepted - delivered)
                else report_mismatch("fifo_count", beat_t'(accepted - delivered), beat_t'(data_cnt));
            // a packet starts only when stored whole or the FIFO is full
            if (m_tvalid && !prev_tvalid && !out_mid) begin
                assert (pkts_held > 0 || int'(data_cnt) == DEPTH)
                    else stop_failed("output opened before a complete packet was stored");
            end
            if (s_tvalid && s_tready) begin
                exp_q.push_back({s_tlast, s_tdata});
                accepted++;
                if (s_tlast) begin
                    pkts_held++;
                end
            end
            if (m_tvalid && m_tready) begin
                got = {m_tlast, m_tdata};
                assert (exp_q.size() > 0)
                    else stop_failed("output beat with no input beat left to match");
                exp_beat = exp_q.pop_front();
                assert (got == exp_beat)
                    else report_mismatch("stream_order", exp_beat, got);
                delivered++;
                out_mid = !m_tlast;
                if (m_tlast) begin
                    pkts_held--;
                end
            end
            prev_tvalid = m_tvalid;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            stop_failed("timeout, packets stopped moving before the run finished");
        end
    end

endmodule

//--- filelist.f
src/axis_pkt_pkg.sv
src/sync_fifo.sv
src/axis_fifo_wrap.sv
src/pkt_count.sv
src/pkt_gate_fsm.sv
src/axis_pkt_buffer.sv
verif/axis_pkt_buffer_checker.sv
verif/tb_axis_pkt_buffer.sv

//--- Makefile
# Verilator flow for the AXI-Stream packet buffer

TOP := tb_axis_pkt_buffer

.PHONY: lint sim clean

# RTL only, the testbench is parsed but not elaborated
lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module axis_pkt_buffer

# the run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -j 0 -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
